//--- rtl/mpf_pkg.sv
/*
 * Memory-side shim stack shared definitions
 * Holds the request and response structs for the AFU, FIU and MMIO
 * ports along with the depths, widths and register map
 */
package mpf_pkg;

    // ====================
    // Sizing
    // ====================

    // Reorder slots, which is also the size of the AFU credit pool
    localparam int rob_depth = 16;
    // One tag per reorder slot
    localparam int tag_w = 4;
    // Request entries the FIU can hold at once
    localparam int fiu_credits = 8;
    // Wide enough to hold the full FIU credit pool
    localparam int credit_w = 4;
    // Width of the in-flight count handed to the register block
    localparam int in_flight_w = 5;

    // ====================
    // Register map
    // ====================

    localparam logic [31:0] feature_id = 32'h4d50_4601;

    localparam logic [1:0] csr_id = 2'd0;
    localparam logic [1:0] csr_scratch = 2'd1;
    localparam logic [1:0] csr_done = 2'd2;
    localparam logic [1:0] csr_in_flight = 2'd3;

    // ====================
    // Port structs
    // ====================

    // The AFU keeps its own metadata, the FIU only ever sees the tag
    typedef struct packed {
        logic [31:0] addr;
        logic [7:0] mdata;
    } afu_req_t;

    typedef struct packed {
        logic [31:0] data;
        logic [7:0] mdata;
    } afu_rsp_t;

    typedef struct packed {
        logic [31:0] addr;
        logic [tag_w-1:0] tag;
    } fiu_req_t;

    typedef struct packed {
        logic [31:0] data;
        logic [tag_w-1:0] tag;
    } fiu_rsp_t;

    typedef struct packed {
        logic write;
        logic [1:0] reg_sel;
        logic [31:0] wdata;
    } mmio_req_t;

endpackage

//--- rtl/mpf_rob.sv
/*
 * Read reorder buffer
 * Allocates one slot per AFU read and uses the slot index as the FIU tag.
 * Keeps the AFU metadata in the slot and hands responses back to the AFU
 * strictly in request order, returning one AFU credit per response
 */
`timescale 1ns/1ps

module mpf_rob (
    input  logic clk,
    input  logic rst_n,
    input  logic afu_req_valid,
    input  mpf_pkg::afu_req_t afu_req,
    input  logic edge_ready,
    input  logic fiu_rsp_valid,
    input  mpf_pkg::fiu_rsp_t fiu_rsp,
    output logic rob_req_valid,
    output mpf_pkg::fiu_req_t rob_req,
    output logic afu_rsp_valid,
    output mpf_pkg::afu_rsp_t afu_rsp,
    output logic afu_credit,
    output logic read_done
);

    // Per-slot request copy and returned data
    mpf_pkg::afu_req_t slot_req [mpf_pkg::rob_depth];
    logic [31:0] slot_data [mpf_pkg::rob_depth];
    // Set when the FIU response for a slot has landed
    logic [mpf_pkg::rob_depth-1:0] slot_filled;

    // Allocation, issue and drain all walk the slots in the same order
    logic [mpf_pkg::tag_w-1:0] alloc_ptr;
    logic [mpf_pkg::tag_w-1:0] issue_ptr;
    logic [mpf_pkg::tag_w-1:0] drain_ptr;

    logic pending;
    logic load_en;
    logic drain_en;
    logic [31:0] issue_addr;

    // ====================
    // Issue toward the edge
    // ====================

    // Slots allocated but not yet moved into the holding register
    assign pending = (alloc_ptr != issue_ptr);

    // The holding register takes a new request when it is empty or when
    // the edge stage consumes its current one in this cycle
    assign load_en = (!rob_req_valid || edge_ready) && (pending || afu_req_valid);

    // With nothing queued the new AFU request bypasses its slot, which keeps
    // the request path at one cycle through this stage
    assign issue_addr = pending ? slot_req[issue_ptr].addr : afu_req.addr;

    // ====================
    // Drain toward the AFU
    // ====================

    // Only the oldest slot may drain, and only once its data is back
    assign drain_en = slot_filled[drain_ptr];

    // Slot storage needs no reset because the filled flags guard it
    always_ff @(posedge clk) begin
        if (afu_req_valid) begin
            slot_req[alloc_ptr] <= afu_req;
        end
        if (fiu_rsp_valid) begin
            slot_data[fiu_rsp.tag] <= fiu_rsp.data;
        end
    end

    // Payload registers follow their valid bits
    always_ff @(posedge clk) begin
        if (load_en) begin
            rob_req.addr <= issue_addr;
            rob_req.tag <= issue_ptr;
        end
        if (drain_en) begin
            afu_rsp.data <= slot_data[drain_ptr];
            afu_rsp.mdata <= slot_req[drain_ptr].mdata;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            alloc_ptr <= '0;
            issue_ptr <= '0;
            drain_ptr <= '0;
            slot_filled <= '0;
            rob_req_valid <= 1'b0;
            afu_rsp_valid <= 1'b0;
        end else begin
            // AFU credits guarantee a free slot for every request
            if (afu_req_valid) begin
                alloc_ptr <= alloc_ptr + 1'b1;
            end

            if (load_en) begin
                issue_ptr <= issue_ptr + 1'b1;
                rob_req_valid <= 1'b1;
            end else if (edge_ready) begin
                rob_req_valid <= 1'b0;
            end

            // Fill and drain never touch the same slot in one cycle
            if (drain_en) begin
                slot_filled[drain_ptr] <= 1'b0;
                drain_ptr <= drain_ptr + 1'b1;
            end
            if (fiu_rsp_valid) begin
                slot_filled[fiu_rsp.tag] <= 1'b1;
            end

            afu_rsp_valid <= drain_en;
        end
    end

    // A delivered response frees its slot, so the credit and the completion
    // event go out with the response itself
    assign afu_credit = afu_rsp_valid;
    assign read_done = afu_rsp_valid;

endmodule

//--- rtl/mpf_edge_fiu.sv
/*
 * FIU edge stage
 * Holds the request register toward the FIU, spends one FIU credit per
 * issued request and counts reads that are issued but not yet answered
 */
`timescale 1ns/1ps

module mpf_edge_fiu (
    input  logic clk,
    input  logic rst_n,
    input  logic rob_req_valid,
    input  mpf_pkg::fiu_req_t rob_req,
    input  logic fiu_credit,
    input  logic fiu_rsp_valid,
    output logic edge_ready,
    output logic fiu_req_valid,
    output mpf_pkg::fiu_req_t fiu_req,
    output logic [mpf_pkg::in_flight_w-1:0] in_flight_count
);

    // Output register occupancy
    logic out_valid;
    // Free request entries on the FIU side
    logic [mpf_pkg::credit_w-1:0] credit_cnt;
    logic take;
    logic issue;

    // ====================
    // Handshake
    // ====================

    // The held request goes out as soon as a credit is available
    assign issue = out_valid && (credit_cnt != '0);
    assign fiu_req_valid = issue;

    // Ready when the register is empty or is emptied by an issue this cycle
    assign edge_ready = !out_valid || (credit_cnt != '0);
    assign take = rob_req_valid && edge_ready;

    // The request payload needs no reset
    always_ff @(posedge clk) begin
        if (take) begin
            fiu_req <= rob_req;
        end
    end

    // ====================
    // Counters
    // ====================

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
            // The FIU starts out with all its entries free
            credit_cnt <= mpf_pkg::credit_w'(mpf_pkg::fiu_credits);
            in_flight_count <= '0;
        end else begin
            if (take) begin
                out_valid <= 1'b1;
            end else if (issue) begin
                out_valid <= 1'b0;
            end

            // A returned credit and an issue in one cycle cancel out
            credit_cnt <= credit_cnt
                        + mpf_pkg::credit_w'(fiu_credit)
                        - mpf_pkg::credit_w'(issue);

            // Counts from issue until the FIU response arrives
            in_flight_count <= in_flight_count
                             + mpf_pkg::in_flight_w'(issue)
                             - mpf_pkg::in_flight_w'(fiu_rsp_valid);
        end
    end

endmodule

//--- rtl/mpf_csr.sv
/*
 * MMIO register block
 * Serves the feature identifier, a scratch register, the completed-read
 * counter and the current in-flight count, with read data one cycle later
 */
`timescale 1ns/1ps

module mpf_csr (
    input  logic clk,
    input  logic rst_n,
    input  logic mmio_valid,
    input  mpf_pkg::mmio_req_t mmio_req,
    input  logic read_done,
    input  logic [mpf_pkg::in_flight_w-1:0] in_flight_count,
    output logic mmio_rsp_valid,
    output logic [31:0] mmio_rsp_data
);

    logic [31:0] scratch;
    // Responses delivered to the AFU since reset or the last clear
    logic [31:0] done_cnt;
    logic [31:0] rd_data;
    logic wr_en;
    logic rd_en;

    assign wr_en = mmio_valid && mmio_req.write;
    assign rd_en = mmio_valid && !mmio_req.write;

    // ====================
    // Read mux
    // ====================

    always_comb begin
        case (mmio_req.reg_sel)
            mpf_pkg::csr_id: rd_data = mpf_pkg::feature_id;
            mpf_pkg::csr_scratch: rd_data = scratch;
            mpf_pkg::csr_done: rd_data = done_cnt;
            default: rd_data = 32'(in_flight_count);
        endcase
    end

    // ====================
    // Register state
    // ====================

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            scratch <= '0;
            done_cnt <= '0;
            mmio_rsp_valid <= 1'b0;
        end else begin
            if (wr_en && (mmio_req.reg_sel == mpf_pkg::csr_scratch)) begin
                scratch <= mmio_req.wdata;
            end

            // A host clear wins over a completion in the same cycle
            if (wr_en && (mmio_req.reg_sel == mpf_pkg::csr_done)) begin
                done_cnt <= '0;
            end else if (read_done) begin
                done_cnt <= done_cnt + 1'b1;
            end

            // Writes get no response
            mmio_rsp_valid <= rd_en;
        end
    end

    // The read data only matters while mmio_rsp_valid is high
    always_ff @(posedge clk) begin
        if (rd_en) begin
            mmio_rsp_data <= rd_data;
        end
    end

endmodule

//--- rtl/mpf_top.sv
/*
 * Memory-side shim stack top level
 * Places the reorder buffer and the FIU edge stage on the read path
 * between the AFU and the FIU and hangs the MMIO register block beside them
 */
`timescale 1ns/1ps

module mpf_top (
    input  logic clk,
    input  logic rst_n,
    // AFU side
    input  logic afu_req_valid,
    input  mpf_pkg::afu_req_t afu_req,
    output logic afu_credit,
    output logic afu_rsp_valid,
    output mpf_pkg::afu_rsp_t afu_rsp,
    // FIU side
    output logic fiu_req_valid,
    output mpf_pkg::fiu_req_t fiu_req,
    input  logic fiu_credit,
    input  logic fiu_rsp_valid,
    input  mpf_pkg::fiu_rsp_t fiu_rsp,
    // Host MMIO
    input  logic mmio_valid,
    input  mpf_pkg::mmio_req_t mmio_req,
    output logic mmio_rsp_valid,
    output logic [31:0] mmio_rsp_data
);

    // Tagged request from the reorder buffer into the edge stage
    logic rob_req_valid;
    mpf_pkg::fiu_req_t rob_req;
    logic edge_ready;
    // Event and status lines into the register block
    logic read_done;
    logic [mpf_pkg::in_flight_w-1:0] in_flight_count;

    // ====================
    // AFU facing stage
    // ====================

    mpf_rob rob (
        .clk,
        .rst_n,
        .afu_req_valid,
        .afu_req,
        .edge_ready,
        .fiu_rsp_valid,
        .fiu_rsp,
        .rob_req_valid,
        .rob_req,
        .afu_rsp_valid,
        .afu_rsp,
        .afu_credit,
        .read_done
    );

    // ====================
    // FIU facing stage
    // ====================

    mpf_edge_fiu edge_fiu (
        .clk,
        .rst_n,
        .rob_req_valid,
        .rob_req,
        .fiu_credit,
        .fiu_rsp_valid,
        .edge_ready,
        .fiu_req_valid,
        .fiu_req,
        .in_flight_count
    );

    // ====================
    // Registers
    // ====================

    mpf_csr csr (
        .clk,
        .rst_n,
        .mmio_valid,
        .mmio_req,
        .read_done,
        .in_flight_count,
        .mmio_rsp_valid,
        .mmio_rsp_data
    );

endmodule

//--- sim/mpf_chk.sv
/*
 * Protocol checker for the shim stack
 * Follows the FIU credits and the returned tags at the ports of mpf_top
 * and flags credit and ordering violations
 */
`timescale 1ns/1ps

module mpf_chk (
    input logic clk,
    input logic rst_n,
    input logic fiu_req_valid,
    input logic fiu_credit,
    input logic fiu_rsp_valid,
    input logic [mpf_pkg::tag_w-1:0] fiu_rsp_tag,
    input logic afu_rsp_valid,
    input logic [mpf_pkg::credit_w-1:0] credit_cnt
);

    // Number of failed assertions so far
    int unsigned assert_fails = 0;
    // FIU entries taken by requests and not yet handed back
    logic [mpf_pkg::credit_w-1:0] fiu_used;
    // Tags whose FIU response has arrived but has not reached the AFU
    logic [mpf_pkg::rob_depth-1:0] returned;
    // Tags go out in request order, so this is the oldest outstanding read
    logic [mpf_pkg::tag_w-1:0] oldest_tag;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            fiu_used <= '0;
            returned <= '0;
            oldest_tag <= '0;
        end else begin
            fiu_used <= fiu_used
                      + mpf_pkg::credit_w'(fiu_req_valid)
                      - mpf_pkg::credit_w'(fiu_credit);
            if (afu_rsp_valid) begin
                returned[oldest_tag] <= 1'b0;
                oldest_tag <= oldest_tag + 1'b1;
            end
            if (fiu_rsp_valid) begin
                returned[fiu_rsp_tag] <= 1'b1;
            end
        end
    end

    // Every request on the FIU port is covered by a credit
    credit_covered: assert property (@(posedge clk) disable iff (!rst_n)
        fiu_req_valid |-> (fiu_used < mpf_pkg::credit_w'(mpf_pkg::fiu_credits)))
        else begin
            assert_fails++;
            $error("FIU request issued with no credit left");
        end

    // The FIU never hands back more entries than it has
    credit_bounded: assert property (@(posedge clk) disable iff (!rst_n)
        credit_cnt <= mpf_pkg::credit_w'(mpf_pkg::fiu_credits))
        else begin
            assert_fails++;
            $error("FIU credit count above the FIU depth");
        end

    // A response only reaches the AFU once the oldest read has its data back
    drain_in_order: assert property (@(posedge clk) disable iff (!rst_n)
        afu_rsp_valid |-> returned[oldest_tag])
        else begin
            assert_fails++;
            $error("AFU response sent while the oldest read had no FIU data");
        end

endmodule

//--- sim/mpf_tb.sv
/*
 * Testbench for the memory-side shim stack
 * Replays a trace of AFU reads and MMIO accesses against mpf_top, models
 * an FIU that answers out of order after random delays, and checks the
 * response order, data, AFU credits and register values
 */
`timescale 1ns/1ps

module mpf_tb;

    localparam int max_steps = 64;

    logic clk;
    logic rst_n;
    logic afu_req_valid;
    mpf_pkg::afu_req_t afu_req;
    logic afu_credit;
    logic afu_rsp_valid;
    mpf_pkg::afu_rsp_t afu_rsp;
    logic fiu_req_valid;
    mpf_pkg::fiu_req_t fiu_req;
    logic fiu_credit;
    logic fiu_rsp_valid;
    mpf_pkg::fiu_rsp_t fiu_rsp;
    logic mmio_valid;
    mpf_pkg::mmio_req_t mmio_req;
    logic mmio_rsp_valid;
    logic [31:0] mmio_rsp_data;

    // One entry per trace step, and only test headers carry a name
    string tr_op [max_steps];
    string tr_name [max_steps];
    logic [31:0] tr_a [max_steps];
    logic [31:0] tr_b [max_steps];
    logic [31:0] tr_c [max_steps];
    int n_steps;
    bit trace_ok;

    // Expected AFU responses in issue order with the data above the mdata
    logic [39:0] expect_q [$];
    logic [39:0] rsp_head;

    // FIU model state with one entry per tag
    logic fiu_busy [mpf_pkg::rob_depth];
    logic [31:0] fiu_addr [mpf_pkg::rob_depth];
    int fiu_due [mpf_pkg::rob_depth];
    int pick;
    int cycle;
    integer seed = 30925;
    // While set the FIU model keeps every response
    logic hold;
    int held_issued;

    int credits;
    int watchdog;
    int cycle_limit;
    logic mmio_got;
    logic [31:0] mmio_data;

    string test_name = "setup";
    bit test_open;
    int test_errors;
    int tests_run;
    int tests_failed;
    int checks;
    int errors;

    mpf_top dut (.*);

    bind mpf_top mpf_chk chk (
        .clk,
        .rst_n,
        .fiu_req_valid,
        .fiu_credit,
        .fiu_rsp_valid,
        .fiu_rsp_tag(fiu_rsp.tag),
        .afu_rsp_valid,
        .credit_cnt(edge_fiu.credit_cnt)
    );

    always #10 clk = ~clk;

    // ====================
    // Reporting
    // ====================

    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        if (expected !== actual) begin
            $display("** Error %s, %s: expected 0x%08h, actual 0x%08h",
                     test_name, what, expected, actual);
            test_errors++;
            errors++;
        end
    endtask

    task automatic report_failure(input string what);
        $display("Failure in test %s: %s", test_name, what);
        test_errors++;
        errors++;
    endtask

    task automatic finish_test();
        tests_run++;
        if (test_errors == 0) begin
            $display("Test %s: pass", test_name);
        end else begin
            tests_failed++;
            $display("Test %s: failed with %0d errors", test_name, test_errors);
        end
        test_open = 1'b0;
    endtask

    // ====================
    // Trace and stimulus
    // ====================

    task automatic load_trace(output bit ok);
        int fd;
        int got;
        string line;
        string op_s;
        string name_s;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] c;
        n_steps = 0;
        fd = $fopen("sim/mpf_trace.txt", "r");
        ok = (fd != 0);
        if (ok) begin
            while (!$feof(fd) && n_steps < max_steps) begin
                line = "";
                op_s = "";
                name_s = "";
                a = '0;
                b = '0;
                c = '0;
                void'($fgets(line, fd));
                got = $sscanf(line, "%s %h %h %h", op_s, a, b, c);
                // Blank lines and lines starting with a lone # carry no step
                if (got >= 1 && op_s != "#") begin
                    if (op_s == "T") begin
                        void'($sscanf(line, "%s %s", op_s, name_s));
                    end
                    tr_op[n_steps] = op_s;
                    tr_name[n_steps] = name_s;
                    tr_a[n_steps] = a;
                    tr_b[n_steps] = b;
                    tr_c[n_steps] = c;
                    n_steps++;
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    // Spends one AFU credit, so it stalls while the credit pool is empty
    task automatic issue_read(input logic [31:0] addr, input logic [7:0] mdata,
                              input logic [31:0] data);
        while (credits == 0) begin
            next_cycle();
        end
        afu_req_valid = 1'b1;
        afu_req.addr = addr;
        afu_req.mdata = mdata;
        credits--;
        expect_q.push_back({data, mdata});
        next_cycle();
        afu_req_valid = 1'b0;
    endtask

    task automatic mmio_write(input logic [1:0] sel, input logic [31:0] data);
        mmio_valid = 1'b1;
        mmio_req.write = 1'b1;
        mmio_req.reg_sel = sel;
        mmio_req.wdata = data;
        next_cycle();
        mmio_valid = 1'b0;
    endtask

    task automatic mmio_read(input logic [1:0] sel, input logic [31:0] expected);
        mmio_valid = 1'b1;
        mmio_req.write = 1'b0;
        mmio_req.reg_sel = sel;
        mmio_req.wdata = '0;
        mmio_got = 1'b0;
        next_cycle();
        mmio_valid = 1'b0;
        while (!mmio_got) begin
            next_cycle();
        end
        check_value($sformatf("register %0d", sel), expected, mmio_data);
    endtask

    task automatic run_step(input int s);
        case (tr_op[s])
            "T": begin
                test_name = tr_name[s];
                test_errors = 0;
                test_open = 1'b1;
            end
            "E": finish_test();
            "R": issue_read(tr_a[s], tr_b[s][7:0], tr_c[s]);
            // A burst reads addresses four bytes apart and expects each one inverted
            "B": for (int k = 0; k < int'(tr_b[s]); k++) begin
                issue_read(tr_a[s] + 32'(4 * k), 8'(tr_c[s] + 32'(k)),
                           ~(tr_a[s] + 32'(4 * k)));
            end
            "W": mmio_write(tr_a[s][1:0], tr_b[s]);
            "M": mmio_read(tr_a[s][1:0], tr_b[s]);
            "H": begin
                hold = tr_a[s][0];
                held_issued = 0;
            end
            "I": repeat (tr_a[s]) next_cycle();
            "S": while (expect_q.size() != 0) next_cycle();
            "K": check_value("AFU credits", tr_a[s], 32'(credits));
            "C": check_value("FIU requests while held", tr_a[s], 32'(held_issued));
            default: report_failure($sformatf("unknown trace operation %s", tr_op[s]));
        endcase
    endtask

    // ====================
    // Models and monitors
    // ====================

    // The FIU model sends at most one response per cycle and picks the lowest ready tag
    always @(posedge clk) begin
        cycle++;
        if (fiu_req_valid) begin
            fiu_busy[fiu_req.tag] = 1'b1;
            fiu_addr[fiu_req.tag] = fiu_req.addr;
            fiu_due[fiu_req.tag] = cycle + 1 + int'($unsigned($random(seed)) % 12);
            if (hold) begin
                held_issued++;
            end
        end
        pick = -1;
        for (int i = 0; i < mpf_pkg::rob_depth; i++) begin
            if (!hold && pick < 0 && fiu_busy[i] && fiu_due[i] <= cycle) begin
                pick = i;
            end
        end
        #1;
        if (pick >= 0) begin
            fiu_rsp_valid = 1'b1;
            fiu_credit = 1'b1;
            fiu_rsp.data = ~fiu_addr[pick];
            fiu_rsp.tag = pick[mpf_pkg::tag_w-1:0];
            fiu_busy[pick] = 1'b0;
        end else begin
            fiu_rsp_valid = 1'b0;
            fiu_credit = 1'b0;
        end
    end

    always @(posedge clk) begin
        if (afu_credit) begin
            credits++;
            if (credits > mpf_pkg::rob_depth) begin
                check_value("AFU credits held", mpf_pkg::rob_depth, 32'(credits));
            end
        end
        if (afu_rsp_valid) begin
            if (expect_q.size() == 0) begin
                report_failure("an AFU response arrived with no read outstanding");
            end else begin
                rsp_head = expect_q.pop_front();
                check_value("response data", rsp_head[39:8], afu_rsp.data);
                check_value("response mdata", 32'(rsp_head[7:0]), 32'(afu_rsp.mdata));
            end
        end
        if (mmio_rsp_valid) begin
            mmio_got = 1'b1;
            mmio_data = mmio_rsp_data;
        end
    end

    always @(posedge clk) begin
        watchdog++;
        if (cycle_limit > 0 && watchdog > cycle_limit) begin
            $display("Timeout in test %s after %0d cycles, the DUT stopped answering",
                     test_name, watchdog);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    // ====================
    // Main sequence
    // ====================

    initial begin
        clk = 1'b0;
        rst_n = 1'b0;
        afu_req_valid = 1'b0;
        afu_req = '0;
        fiu_credit = 1'b0;
        fiu_rsp_valid = 1'b0;
        fiu_rsp = '0;
        mmio_valid = 1'b0;
        mmio_req = '0;
        hold = 1'b0;
        mmio_got = 1'b0;
        credits = mpf_pkg::rob_depth;
        for (int t = 0; t < mpf_pkg::rob_depth; t++) begin
            fiu_busy[t] = 1'b0;
        end
        load_trace(trace_ok);
        cycle_limit = 40 * n_steps + 200;
        if (!trace_ok) begin
            $display("Could not open the trace file sim/mpf_trace.txt");
            $display("*** TEST FAILED ***");
        end else begin
            repeat (4) @(posedge clk);
            #1;
            rst_n = 1'b1;
            next_cycle();
            for (int s = 0; s < n_steps; s++) begin
                run_step(s);
            end
            if (test_open) begin
                finish_test();
            end
            errors += int'(dut.chk.assert_fails);
            $display("Tests run %0d, failed %0d, checks %0d, errors %0d, assertion failures %0d",
                     tests_run, tests_failed, checks, errors, dut.chk.assert_fails);
            if (errors == 0 && tests_failed == 0) begin
                $display("*** TEST PASSED ***");
            end else begin
                $display("*** TEST FAILED ***");
            end
        end
        $finish;
    end

endmodule

//--- sim/mpf_trace.txt
# Columns are op, arg1, arg2, arg3, and every number is hex
# T name | R addr mdata data | B addr count mdata0 | W reg data | M reg value
# H hold | I cycles | S (wait for all reads) | K credits | C fiu_reqs | E
T burst_order
R 00001000 11 ffffefff
R 00001004 22 ffffeffb
R 00001040 33 ffffefbf
R 12345678 44 edcba987
R a5a5a5a5 55 5a5a5a5a
R 0000ff00 66 ffff00ff
S
E
T credit_drain
H 1
B 00010000 10 a0
I 10
K 0
C 8
H 0
S
K 10
E
T fiu_limit
H 1
B 00020000 0c 30
I 10
C 8
M 3 8
H 0
S
M 3 0
E
T mmio_regs
M 0 4d504601
W 1 cafef00d
M 1 cafef00d
W 0 12345678
M 0 4d504601
W 3 00000005
M 3 0
E
T done_count
M 2 22
W 2 0
M 2 0
B 00030000 3 f0
S
M 2 3
E

//--- project.f
rtl/mpf_pkg.sv
rtl/mpf_rob.sv
rtl/mpf_edge_fiu.sv
rtl/mpf_csr.sv
rtl/mpf_top.sv
sim/mpf_chk.sv
sim/mpf_tb.sv

//--- Bender.yml
package:
  name: mpf_shim

sources:
  - rtl/mpf_pkg.sv
  - rtl/mpf_rob.sv
  - rtl/mpf_edge_fiu.sv
  - rtl/mpf_csr.sv
  - rtl/mpf_top.sv
  - target: simulation
    files:
      - sim/mpf_chk.sv
      - sim/mpf_tb.sv
